// File: hw/npu_types_pkg.sv
package npu_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  localparam int DATA_W = 16;
  localparam int PSUM_W = 2 * DATA_W;   // Products of two lanes, wraps
  localparam int BEAT_W = 64;

  // Lanes per input beat, lane 0 in the low bits
  localparam int LANES_PER_BEAT = BEAT_W / DATA_W;

  ////////////////////////////////////////////////////////////////////////////
  // Types

  // One activation or weight
  typedef logic signed [DATA_W-1:0] data_t;

  // One dot-product result
  typedef logic signed [PSUM_W-1:0] psum_t;

  typedef logic [BEAT_W-1:0] beat_t;

endpackage

// File: hw/npu_ctrl_pkg.sv
package npu_ctrl_pkg;

  // Engine FSM
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    W_FILL  = 2'd1,   // Stationary weights loading
    COMPUTE = 2'd2,   // One input read per cycle
    DRAIN   = 2'd3    // Last reads still in flight
  } engine_state_e;

endpackage

// File: hw/row_bus_if.sv
`timescale 1ns/1ns

interface row_bus_if #(
  parameter int SYS_ROW = 4,
  parameter int DEPTH   = 4
) ();

  localparam int LANE_W = 16;                     // One data_t lane
  localparam int ROW_W  = SYS_ROW * LANE_W;
  localparam int AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW     = $clog2(DEPTH + 1);

  // Write side
  logic             wr_en;
  logic [AW-1:0]    wr_addr;
  logic [ROW_W-1:0] wr_data;
  logic [CW-1:0]    rows;      // Rows written in this burst

  // Read side, data one cycle after rd_en
  logic             rd_en;
  logic [AW-1:0]    rd_addr;
  logic [ROW_W-1:0] rd_data;

  modport producer (output wr_en, wr_addr, wr_data, rows);

  modport bank (input wr_en, wr_addr, wr_data, rd_en, rd_addr, output rd_data);

  modport consumer (output rd_en, rd_addr, input rd_data, rows);

endinterface

// File: hw/row_packer.sv
`timescale 1ns/1ns

module row_packer import npu_types_pkg::*; #(
  parameter int SYS_ROW = 4,
  parameter int DEPTH   = 4
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        en,
  input  beat_t       beat,
  row_bus_if.producer bus
);

  localparam int BEATS = SYS_ROW / LANES_PER_BEAT;
  localparam int BW    = (BEATS > 1) ? $clog2(BEATS) : 1;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW    = $clog2(DEPTH + 1);

  logic [BW-1:0]       beat_cnt;    // Beat within the row
  logic                en_d;
  logic [CW-1:0]       base_rows;   // Row count this beat builds on
  logic                last_beat;
  data_t [SYS_ROW-1:0] asm_row;
  data_t [SYS_ROW-1:0] next_row;

  // First beat of a burst restarts the count
  assign base_rows = (en && !en_d) ? '0 : bus.rows;
  assign last_beat = (beat_cnt == BW'(BEATS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Row assembly

  always_comb begin
    next_row = asm_row;
    for (int k = 0; k < LANES_PER_BEAT; k++) begin
      next_row[beat_cnt * LANES_PER_BEAT + k] =
        data_t'(beat[k * $bits(data_t) +: $bits(data_t)]);
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      asm_row <= next_row;
    end
  end

  // Completed row sits in asm_row while wr_en is high
  assign bus.wr_data = asm_row;

  ////////////////////////////////////////////////////////////////////////////
  // Beat and row counting

  always_ff @(posedge clk) begin
    if (!rstn) begin
      beat_cnt    <= '0;
      en_d        <= 1'b0;
      bus.wr_en   <= 1'b0;
      bus.wr_addr <= '0;
      bus.rows    <= '0;
    end else begin
      en_d      <= en;
      bus.wr_en <= 1'b0;
      if (!en) begin
        beat_cnt <= '0;             // Partial row is dropped
      end else if (last_beat) begin
        beat_cnt <= '0;
        if (base_rows < CW'(DEPTH)) begin
          bus.wr_en   <= 1'b1;
          bus.wr_addr <= base_rows[AW-1:0];
          bus.rows    <= base_rows + 1'b1;
        end else begin
          bus.rows <= base_rows;    // Bank full
        end
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
        bus.rows <= base_rows;
      end
    end
  end

endmodule

// File: hw/row_bank.sv
`timescale 1ns/1ns

module row_bank import npu_types_pkg::*; #(
  parameter int SYS_ROW = 4,
  parameter int DEPTH   = 4
) (
  input  logic    clk,
  input  logic    rstn,
  row_bus_if.bank bus
);

  // One full row per entry
  data_t [SYS_ROW-1:0] mem [DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // Write port

  always_ff @(posedge clk) begin
    if (bus.wr_en) begin
      mem[bus.wr_addr] <= bus.wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port, one cycle latency

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bus.rd_data <= '0;
    end else if (bus.rd_en) begin
      bus.rd_data <= mem[bus.rd_addr];
    end
  end

endmodule

// File: hw/mac_engine.sv
`timescale 1ns/1ns

module mac_engine import npu_types_pkg::*, npu_ctrl_pkg::*; #(
  parameter int SYS_ROW  = 4,
  parameter int SYS_COL  = 4,
  parameter int IN_DEPTH = 16
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic [15:0]         num_in,
  row_bus_if.consumer         w_bus,
  row_bus_if.consumer         in_bus,
  output logic                busy,
  output logic                out_valid,
  output logic [15:0]         out_row,
  output psum_t [SYS_COL-1:0] out_data
);

  localparam int W_AW  = (SYS_ROW > 1) ? $clog2(SYS_ROW) : 1;
  localparam int IN_AW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int FW    = $clog2(SYS_ROW + 1);

  engine_state_e state;

  logic [FW-1:0]   fill_cnt;    // Weight reads issued
  logic [15:0]     rd_cnt;      // Input reads issued
  logic            in_hit;
  logic            in_hit_d;
  logic            start;
  logic            w_rd_v;
  logic [W_AW-1:0] w_rd_idx;
  logic            rd_v;
  logic [15:0]     rd_row;

  data_t [SYS_ROW-1:0] w_grid [SYS_ROW];   // [input lane][output column]
  data_t [SYS_ROW-1:0] w_lanes;
  data_t [SYS_ROW-1:0] in_lanes;
  psum_t [SYS_COL-1:0] dot;

  // Start on the input count reaching num_in, weights already loaded
  assign in_hit = (16'(in_bus.rows) == num_in);
  assign start  = (state == IDLE) && in_hit && !in_hit_d && (int'(w_bus.rows) == SYS_ROW);

  assign busy = (state != IDLE);

  assign w_bus.rd_en   = (state == W_FILL) && (fill_cnt < FW'(SYS_ROW));
  assign w_bus.rd_addr = fill_cnt[W_AW-1:0];
  assign in_bus.rd_en   = (state == COMPUTE) && (rd_cnt < num_in);
  assign in_bus.rd_addr = rd_cnt[IN_AW-1:0];

  assign w_lanes  = w_bus.rd_data;
  assign in_lanes = in_bus.rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= IDLE;
      fill_cnt  <= '0;
      rd_cnt    <= '0;
      in_hit_d  <= 1'b0;
      w_rd_v    <= 1'b0;
      rd_v      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      in_hit_d  <= in_hit;
      w_rd_v    <= w_bus.rd_en;
      rd_v      <= in_bus.rd_en;
      out_valid <= rd_v;
      case (state)
        IDLE: begin
          fill_cnt <= '0;
          rd_cnt   <= '0;
          if (start) begin
            state <= W_FILL;
          end
        end
        W_FILL: begin
          fill_cnt <= fill_cnt + 1'b1;
          if (fill_cnt == FW'(SYS_ROW)) begin   // Last weight row lands now
            fill_cnt <= '0;
            state    <= COMPUTE;
          end
        end
        COMPUTE: begin
          rd_cnt <= rd_cnt + 1'b1;
          if ({1'b0, rd_cnt} + 17'd1 >= {1'b0, num_in}) begin
            state <= DRAIN;
          end
        end
        DRAIN: begin
          if (!rd_v) begin
            state <= IDLE;                      // Last result on out_valid
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath

  always_comb begin
    psum_t acc;
    for (int c = 0; c < SYS_COL; c++) begin
      acc = '0;
      for (int r = 0; r < SYS_ROW; r++) begin
        acc += psum_t'(in_lanes[r]) * psum_t'(w_grid[r][c]);
      end
      dot[c] = (acc < 0) ? '0 : acc;  // ReLU
    end
  end

  always_ff @(posedge clk) begin
    w_rd_idx <= fill_cnt[W_AW-1:0];
    rd_row   <= rd_cnt;
    if (w_rd_v) begin
      w_grid[w_rd_idx] <= w_lanes;
    end
    if (rd_v) begin
      out_row  <= rd_row;
      out_data <= dot;
    end
  end

endmodule

// File: hw/npu_top.sv
`timescale 1ns/1ns

module npu_top import npu_types_pkg::*; #(
  parameter int SYS_ROW  = 4,
  parameter int SYS_COL  = 4,
  parameter int IN_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic [15:0]               num_in,
  input  logic                      w_en,
  input  beat_t                     w_data,
  input  logic                      in_en,
  input  beat_t                     in_data,
  output logic                      busy,
  output logic                      out_valid,
  output logic [15:0]               out_row,
  output logic [SYS_COL*PSUM_W-1:0] out_data    // Column 0 in the low bits
);

  row_bus_if #(.SYS_ROW(SYS_ROW), .DEPTH(SYS_ROW))  w_bus  ();
  row_bus_if #(.SYS_ROW(SYS_ROW), .DEPTH(IN_DEPTH)) in_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Weight path

  row_packer #(.SYS_ROW(SYS_ROW), .DEPTH(SYS_ROW)) w_packer (
    .clk  (clk),
    .rstn (rstn),
    .en   (w_en),
    .beat (w_data),
    .bus  (w_bus)
  );

  row_bank #(.SYS_ROW(SYS_ROW), .DEPTH(SYS_ROW)) w_bank (
    .clk  (clk),
    .rstn (rstn),
    .bus  (w_bus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Input path

  row_packer #(.SYS_ROW(SYS_ROW), .DEPTH(IN_DEPTH)) in_packer (
    .clk  (clk),
    .rstn (rstn),
    .en   (in_en),
    .beat (in_data),
    .bus  (in_bus)
  );

  row_bank #(.SYS_ROW(SYS_ROW), .DEPTH(IN_DEPTH)) in_bank (
    .clk  (clk),
    .rstn (rstn),
    .bus  (in_bus)
  );

  mac_engine #(.SYS_ROW(SYS_ROW), .SYS_COL(SYS_COL), .IN_DEPTH(IN_DEPTH)) engine (
    .clk       (clk),
    .rstn      (rstn),
    .num_in    (num_in),
    .w_bus     (w_bus),
    .in_bus    (in_bus),
    .busy      (busy),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_data  (out_data)
  );

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rstn
);

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  // Release on a falling edge, away from the sampling edge
  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// File: sim/tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
  parameter int SYS_ROW  = 4,
  parameter int SYS_COL  = 4,
  parameter int IN_DEPTH = 16
) (
  input logic                  clk,
  input logic                  rstn,
  input logic                  busy,
  input logic                  out_valid,
  input logic [15:0]           out_row,
  input logic [SYS_COL*32-1:0] out_data
);

  // Filled by tb_top before each run
  logic signed [15:0] w_ref [SYS_ROW][SYS_COL];    // [input lane][column]
  logic signed [15:0] in_ref [IN_DEPTH][SYS_ROW];
  int   exp_rows = 0;
  logic armed    = 1'b0;   // Loads complete, engine may start

  int   err_cnt     = 0;
  int   miss_cnt    = 0;
  int   extra_cnt   = 0;
  int   checked_cnt = 0;
  int   row_cnt     = 0;   // Rows seen in the current run
  logic busy_q      = 1'b0;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [SYS_COL*32-1:0] expected_row(input int row);
    logic [SYS_COL*32-1:0] res;
    int acc;
    res = '0;
    for (int c = 0; c < SYS_COL; c++) begin
      acc = 0;
      for (int r = 0; r < SYS_ROW; r++) begin
        acc += int'(in_ref[row][r]) * int'(w_ref[r][c]);   // Wraps at 32 bits
      end
      if (acc < 0) acc = 0;
      res[c*32 +: 32] = acc;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare, sampled on the falling edge

  always @(negedge clk) begin
    logic [SYS_COL*32-1:0] exp;
    if (rstn) begin
      if ((busy || out_valid) && !armed) begin
        err_cnt++;
        $display("[ERROR] %0t: busy=%0b out_valid=%0b before loads completed",
                 $time, busy, out_valid);
      end
      if (out_valid && !busy) begin
        extra_cnt++;
        $display("[ERROR] %0t: row %0d seen while not busy", $time, out_row);
      end else if (out_valid && row_cnt >= exp_rows) begin
        extra_cnt++;
        $display("[ERROR] %0t: extra row %0d beyond %0d", $time, out_row, exp_rows);
      end else if (out_valid) begin
        if (out_row != 16'(row_cnt)) begin
          err_cnt++;
          $display("[ERROR] %0t: out_row %0d, expected %0d", $time, out_row, row_cnt);
        end
        if (int'(out_row) < exp_rows) begin
          exp = expected_row(int'(out_row));
          for (int c = 0; c < SYS_COL; c++) begin
            if (out_data[c*32 +: 32] !== exp[c*32 +: 32]) begin
              err_cnt++;
              $display("[ERROR] %0t: row %0d col %0d got %0d expected %0d", $time,
                       out_row, c, $signed(out_data[c*32 +: 32]), $signed(exp[c*32 +: 32]));
            end
          end
        end
        checked_cnt++;
        row_cnt++;
      end
      // End of a run
      if (busy_q && !busy) begin
        if (row_cnt < exp_rows) begin
          miss_cnt += exp_rows - row_cnt;
          $display("[ERROR] %0t: run ended after %0d of %0d rows", $time, row_cnt, exp_rows);
        end
        row_cnt = 0;
      end
      busy_q = busy;
    end
  end

  function automatic int total_errors();
    return err_cnt + miss_cnt + extra_cnt;
  endfunction

  task automatic report_counts();
    $display("Rows checked %0d, errors %0d, missing rows %0d, extra rows %0d",
             checked_cnt, err_cnt, miss_cnt, extra_cnt);
  endtask

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  localparam int SYS_ROW  = 4;
  localparam int SYS_COL  = 4;
  localparam int IN_DEPTH = 16;
  localparam int BEATS    = SYS_ROW / 4;
  localparam int TIMEOUT  = 200;   // Cycles per wait

  logic                  clk;
  logic                  rstn;
  logic [15:0]           num_in;
  logic                  w_en;
  logic [63:0]           w_data;
  logic                  in_en;
  logic [63:0]           in_data;
  logic                  busy;
  logic                  out_valid;
  logic [15:0]           out_row;
  logic [SYS_COL*32-1:0] out_data;

  integer seed;
  bit     timed_out;

  tb_clkgen #(.PERIOD(10), .RST_CYCLES(4)) clk_gen (.clk(clk), .rstn(rstn));

  npu_top #(.SYS_ROW(SYS_ROW), .SYS_COL(SYS_COL), .IN_DEPTH(IN_DEPTH)) dut0 (
    .clk       (clk),
    .rstn      (rstn),
    .num_in    (num_in),
    .w_en      (w_en),
    .w_data    (w_data),
    .in_en     (in_en),
    .in_data   (in_data),
    .busy      (busy),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_data  (out_data)
  );

  tb_checker #(.SYS_ROW(SYS_ROW), .SYS_COL(SYS_COL), .IN_DEPTH(IN_DEPTH)) chk (
    .clk       (clk),
    .rstn      (rstn),
    .busy      (busy),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_data  (out_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus data

  // Low columns positive, high columns negative
  task automatic fill_weights(input bit split);
    int mag;
    for (int r = 0; r < SYS_ROW; r++) begin
      for (int c = 0; c < SYS_COL; c++) begin
        mag = ($random(seed) & 32'h7f) + 1;
        if (!split) chk.w_ref[r][c] = 16'($random(seed));
        else chk.w_ref[r][c] = (c < SYS_COL / 2) ? 16'(mag) : 16'(-mag);
      end
    end
  endtask

  task automatic fill_inputs(input int n, input bit positive);
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < SYS_ROW; k++) begin
        if (positive) chk.in_ref[i][k] = 16'(($random(seed) & 32'hff) + 1);
        else chk.in_ref[i][k] = 16'($random(seed));
      end
    end
  endtask

  task automatic send_rows(input bit is_weight, input int n);
    logic [63:0] beat;
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < BEATS; b++) begin
        for (int k = 0; k < 4; k++) begin
          if (is_weight) beat[k*16 +: 16] = chk.w_ref[i][b*4 + k];
          else beat[k*16 +: 16] = chk.in_ref[i][b*4 + k];
        end
        @(negedge clk);
        if (is_weight) begin
          w_en   = 1'b1;
          w_data = beat;
        end else begin
          in_en   = 1'b1;
          in_data = beat;
        end
      end
    end
    @(negedge clk);
    w_en  = 1'b0;
    in_en = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Waits

  task automatic wait_first_result();
    int cycles;
    cycles = 0;
    while (!out_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!out_valid) begin
      $display("Timeout: no result row within %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_engine_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("Timeout: engine still busy after %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  // Weights first, then inputs, then let the engine run
  task automatic run_layer(input int n, input bit split);
    @(negedge clk);
    num_in       = 16'(n);
    chk.exp_rows = n;
    fill_weights(split);
    fill_inputs(n, split);
    send_rows(1'b1, SYS_ROW);
    send_rows(1'b0, n);
    chk.armed = 1'b1;
    wait_first_result();
    if (!timed_out) wait_engine_idle();
    chk.armed = 1'b0;
  endtask

  initial begin
    seed      = 32'hd38e;
    num_in    = 16'd5;
    w_en      = 1'b0;
    w_data    = '0;
    in_en     = 1'b0;
    in_data   = '0;
    timed_out = 1'b0;
    repeat (6) @(negedge clk);    // Reset done
    run_layer(5, 1'b0);
    if (!timed_out) run_layer(7, 1'b1);         // Negative columns clip to zero
    if (!timed_out) run_layer(IN_DEPTH, 1'b0);  // Reload, full bank
    repeat (4) @(negedge clk);
    chk.report_counts();
    if (!timed_out && chk.total_errors() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/npu_types_pkg.sv
hw/npu_ctrl_pkg.sv
hw/row_bus_if.sv
hw/row_packer.sv
hw/row_bank.sv
hw/mac_engine.sv
hw/npu_top.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f flist.f -o tb_sim
sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
